//--- hdl/spif_pkg.sv
//================================================
// shared widths, register map, flash constants,
// FSM enums and bus structs
//================================================
package spif_pkg;

  localparam int DATA_WIDTH = 24;               // data RAM word width

  typedef logic [7:0]            byte_t;        // uart or flash byte
  typedef logic [DATA_WIDTH-1:0] data_word_t;   // data RAM word
  typedef logic [15:0]           code_word_t;   // code RAM word
  typedef logic [15:0]           dest_addr_t;   // RAM destination
  typedef logic [23:0]           flash_addr_t;  // flash byte address
  typedef logic [3:0]            reg_addr_t;    // apb word index

  localparam byte_t FAST_READ = 8'h0B;          // read with one dummy byte
  localparam byte_t ESC_BYTE  = 8'h10;          // 10h..13h need escaping

  //================================================
  // register map
  //================================================
  localparam reg_addr_t REG_UART      = 4'd0;   // tx byte / rx byte
  localparam reg_addr_t REG_RX_FULL   = 4'd1;
  localparam reg_addr_t REG_TX_BUSY   = 4'd2;
  localparam reg_addr_t REG_BOOT      = 4'd3;   // w: reboot, r: booting
  localparam reg_addr_t REG_CODE_DEST = 4'd4;
  localparam reg_addr_t REG_CODE_DATA = 4'd5;

  typedef enum logic [2:0] {
    B_IDLE, B_OPCODE, B_ADDR2, B_ADDR1, B_ADDR0, B_DUMMY, B_STREAM
  } boot_state_e;                               // order matters, steps by +1

  typedef enum logic [2:0] {
    M_CMD, M_DEST_H, M_DEST_L, M_CNT_H, M_CNT_L, M_DATA
  } stream_mode_e;

  typedef enum logic {RX_IDLE, RX_ESC} rx_state_e;

  typedef struct packed {
    logic       psel;
    logic       penable;
    logic       pwrite;
    reg_addr_t  paddr;
    data_word_t pwdata;
  } apb_req_t;

  typedef struct packed {
    data_word_t prdata;
    logic       pready;
  } apb_rsp_t;

  typedef struct packed {
    logic       code_we;                        // code RAM takes data[15:0]
    logic       data_we;
    dest_addr_t addr;
    data_word_t data;
  } mem_wr_t;

  typedef struct packed {
    logic        start;                         // reboot strobe
    flash_addr_t flash_addr;
    logic        code_dest;                     // load destination
    dest_addr_t  dest;
    logic        code_data;                     // write one code word
    code_word_t  code;
  } boot_cmd_t;

endpackage

//--- hdl/uart_tx_escape.sv
//================================================
// uart tx: 10h..13h go out as 10h, 0x
//================================================
`timescale 1ns/10ps

module uart_tx_escape (
  input  logic             clk,
  input  logic             arstn,
  input  logic             i_tx_wr,
  input  spif_pkg::byte_t  i_tx_byte,
  input  logic             i_u_ready,
  output logic             o_u_wr,
  output spif_pkg::byte_t  o_u_dout,
  output logic             o_tx_busy
);
  import spif_pkg::*;

  logic       escaped;          // tail byte still owed
  logic [1:0] tail;             // low bits of the escaped byte
  logic       is_esc;
  logic       send_tail;

  assign is_esc    = (i_tx_byte[7:2] == ESC_BYTE[7:2]);
  assign send_tail = escaped & i_u_ready & ~o_u_wr;     // uart back-pressure
  assign o_tx_busy = escaped | ~i_u_ready | i_tx_wr | o_u_wr;

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      o_u_wr  <= 1'b0;
      escaped <= 1'b0;
    end else begin
      o_u_wr <= i_tx_wr | send_tail;                    // one-cycle strobe
      if (i_tx_wr)
        escaped <= is_esc;
      else if (send_tail)
        escaped <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (i_tx_wr) begin
      o_u_dout <= is_esc ? ESC_BYTE : i_tx_byte;        // prefix first
      tail     <= i_tx_byte[1:0];
    end else if (send_tail) begin
      o_u_dout <= {6'b000000, tail};
    end
  end

endmodule

//--- hdl/uart_rx_unescape.sv
//================================================
// uart rx: undo 10h, 0x pairs into a holding reg
//================================================
`timescale 1ns/10ps

module uart_rx_unescape (
  input  logic             clk,
  input  logic             arstn,
  input  logic             i_u_full,
  input  spif_pkg::byte_t  i_u_din,
  output logic             o_u_rd,
  input  logic             i_rx_pop,
  output spif_pkg::byte_t  o_rx_byte,
  output logic             o_rx_full
);
  import spif_pkg::*;

  rx_state_e state;
  logic      rx_ok;             // raw byte there, not just popped
  logic      is_esc;
  logic      load;              // pop into holding reg
  logic      skip;              // pop and drop
  byte_t     load_byte;

  assign rx_ok  = i_u_full & ~o_u_rd;
  assign is_esc = (i_u_din[7:2] == ESC_BYTE[7:2]);

  always_comb begin
    load      = 1'b0;
    skip      = 1'b0;
    load_byte = i_u_din;
    if (rx_ok) begin
      if (state == RX_ESC) begin
        load      = ~o_rx_full;                         // waits for room
        load_byte = {ESC_BYTE[7:2], i_u_din[1:0]};
      end else if (is_esc) begin
        skip = 1'b1;                                    // prefix or stray 11h..13h
      end else begin
        load = ~o_rx_full;
      end
    end
  end

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      state     <= RX_IDLE;
      o_u_rd    <= 1'b0;
      o_rx_full <= 1'b0;
    end else begin
      o_u_rd <= load | skip;
      if (i_rx_pop)
        o_rx_full <= 1'b0;
      if (load)
        o_rx_full <= 1'b1;                              // only loads when empty
      if (skip && (i_u_din[1:0] == 2'b00))
        state <= RX_ESC;
      else if (load)
        state <= RX_IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (load)
      o_rx_byte <= load_byte;
  end

endmodule

//--- hdl/boot_loader.sv
//================================================
// flash fast-read sequencer and boot stream
// interpreter feeding the RAM write port
//================================================
`timescale 1ns/10ps

module boot_loader (
  input  logic                 clk,
  input  logic                 arstn,
  input  spif_pkg::boot_cmd_t  i_boot_cmd,
  input  logic                 i_f_ready,
  input  spif_pkg::byte_t      i_f_din,
  output logic                 o_f_wr,
  output spif_pkg::byte_t      o_f_dout,
  output logic                 o_f_cs_n,
  output spif_pkg::mem_wr_t    o_mem,
  output logic                 o_p_reset,
  output logic                 o_booting
);
  import spif_pkg::*;

  boot_state_e  state;
  stream_mode_e mode;
  flash_addr_t  faddr;          // read start address
  dest_addr_t   dest;
  logic [15:0]  count;          // words left minus one
  data_word_t   word;           // msb first shift reg
  logic [2:0]   sink;           // 0 code, 1 data, else discard
  logic [1:0]   bytes;          // bytes per word minus one
  logic [1:0]   bytecnt;
  logic         primed;         // dummy byte already sent
  logic         code_we;
  logic         data_we;
  logic         bump;           // advance dest after a write
  logic         f_ok;
  byte_t        tx_byte;

  assign f_ok      = i_f_ready & ~o_f_wr;               // previous exchange done
  assign o_booting = (state != B_IDLE);

  always_comb begin
    case (state)
      B_OPCODE: tx_byte = FAST_READ;
      B_ADDR2:  tx_byte = faddr[23:16];
      B_ADDR1:  tx_byte = faddr[15:8];
      B_ADDR0:  tx_byte = faddr[7:0];
      default:  tx_byte = 8'h00;                        // dummy and stream clocks
    endcase
  end

  always_comb begin
    o_mem.code_we = code_we;
    o_mem.data_we = data_we;
    o_mem.addr    = dest;
    o_mem.data    = word;
  end

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      state     <= B_OPCODE;                            // boot from flash 0
      mode      <= M_CMD;
      faddr     <= '0;
      dest      <= '0;
      count     <= '0;
      word      <= '0;
      sink      <= '0;
      bytes     <= '0;
      bytecnt   <= '0;
      primed    <= 1'b0;
      code_we   <= 1'b0;
      data_we   <= 1'b0;
      bump      <= 1'b0;
      o_f_wr    <= 1'b0;
      o_f_dout  <= '0;
      o_f_cs_n  <= 1'b1;
      o_p_reset <= 1'b1;
    end else begin
      o_f_wr  <= 1'b0;
      code_we <= 1'b0;
      data_we <= 1'b0;
      bump    <= 1'b0;
      if (bump) begin
        dest <= dest + 16'd1;                           // discarded words count too
        word <= '0;
      end
      case (state)
        B_IDLE: begin                                   // cpu code writes
          if (i_boot_cmd.code_dest)
            dest <= i_boot_cmd.dest;
          if (i_boot_cmd.code_data) begin
            word    <= data_word_t'(i_boot_cmd.code);
            code_we <= 1'b1;
            bump    <= 1'b1;
          end
        end
        B_OPCODE, B_ADDR2, B_ADDR1, B_ADDR0: begin
          if (f_ok) begin
            o_f_wr   <= 1'b1;
            o_f_dout <= tx_byte;
            o_f_cs_n <= 1'b0;
            state    <= boot_state_e'(state + 3'd1);
          end
        end
        B_DUMMY: begin                                  // dummy, then first data clock
          if (f_ok) begin
            o_f_wr   <= 1'b1;
            o_f_dout <= tx_byte;
            primed   <= ~primed;
            if (primed)
              state <= B_STREAM;
          end
        end
        B_STREAM: begin
          if (f_ok) begin
            o_f_wr   <= 1'b1;                           // keep one exchange in flight
            o_f_dout <= tx_byte;
            case (mode)
              M_CMD: begin
                if (i_f_din[7:5] == 3'b111) begin       // end of stream
                  o_f_wr    <= 1'b0;
                  o_f_cs_n  <= 1'b1;
                  o_p_reset <= i_f_din[4];
                  state     <= B_IDLE;
                end else if (i_f_din == 8'hC0) begin
                  mode <= M_DEST_H;
                end else if (i_f_din == 8'hC2) begin
                  mode <= M_CNT_H;
                end else if (!i_f_din[7]) begin         // 00/01: data header
                  mode    <= M_DATA;
                  sink    <= i_f_din[4:2];
                  bytes   <= i_f_din[1:0];
                  bytecnt <= i_f_din[1:0];
                  word    <= '0;
                end
              end
              M_DEST_H: begin
                dest[15:8] <= i_f_din;
                mode       <= M_DEST_L;
              end
              M_DEST_L: begin
                dest[7:0] <= i_f_din;
                mode      <= M_CMD;
              end
              M_CNT_H: begin
                count[15:8] <= i_f_din;
                mode        <= M_CNT_L;
              end
              M_CNT_L: begin
                count[7:0] <= i_f_din;
                mode       <= M_CMD;
              end
              M_DATA: begin
                word <= {word[DATA_WIDTH-9:0], i_f_din};    // 4-byte words lose top byte
                if (bytecnt != 2'd0) begin
                  bytecnt <= bytecnt - 2'd1;
                end else begin
                  bytecnt <= bytes;
                  code_we <= (sink == 3'd0);
                  data_we <= (sink == 3'd1);
                  bump    <= 1'b1;
                  if (count != 16'd0)
                    count <= count - 16'd1;
                  else
                    mode <= M_CMD;
                end
              end
              default: mode <= M_CMD;
            endcase
          end
        end
        default: state <= B_IDLE;
      endcase
      if (i_boot_cmd.start) begin                       // reboot, cs# high for a cycle
        state    <= B_OPCODE;
        faddr    <= i_boot_cmd.flash_addr;
        mode     <= M_CMD;
        primed   <= 1'b0;
        o_f_wr   <= 1'b0;
        o_f_cs_n <= 1'b1;
      end
    end
  end

endmodule

//--- hdl/spif_regs.sv
//================================================
// apb slave: read mux, wait states, command strobes
//================================================
`timescale 1ns/10ps

module spif_regs (
  input  logic                 clk,
  input  logic                 arstn,
  input  spif_pkg::apb_req_t   i_apb,
  output spif_pkg::apb_rsp_t   o_apb,
  input  spif_pkg::byte_t      i_rx_byte,
  input  logic                 i_rx_full,
  input  logic                 i_tx_busy,
  input  logic                 i_booting,
  output logic                 o_tx_wr,
  output spif_pkg::byte_t      o_tx_byte,
  output logic                 o_rx_pop,
  output spif_pkg::boot_cmd_t  o_boot_cmd
);
  import spif_pkg::*;

  logic       stall;            // drives pready low
  logic       access;           // apb access phase
  logic       wr_done;
  logic       rd_done;
  logic       start_q;
  logic       dest_q;
  logic       code_q;
  data_word_t wdata_q;          // last completed write data

  assign access  = i_apb.psel & i_apb.penable;
  assign wr_done = access & i_apb.pwrite & ~stall;
  assign rd_done = access & ~i_apb.pwrite;        // reads never stall

  // only two writes can wait
  always_comb begin
    stall = 1'b0;
    if (i_apb.psel && i_apb.pwrite) begin
      case (i_apb.paddr)
        REG_UART:      stall = i_tx_busy;         // escaper still sending
        REG_CODE_DATA: stall = i_booting;         // loader owns the RAM port
        default:       stall = 1'b0;
      endcase
    end
  end

  always_comb begin
    o_apb.pready = ~stall;
    case (i_apb.paddr)
      REG_UART:    o_apb.prdata = data_word_t'(i_rx_byte);
      REG_RX_FULL: o_apb.prdata = data_word_t'(i_rx_full);
      REG_TX_BUSY: o_apb.prdata = data_word_t'(i_tx_busy);
      REG_BOOT:    o_apb.prdata = data_word_t'(i_booting);
      default:     o_apb.prdata = '0;
    endcase
  end

  assign o_rx_pop = rd_done & (i_apb.paddr == REG_UART);    // full drops next cycle

  //================================================
  // write strobes, one cycle after the apb edge
  //================================================
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      o_tx_wr <= 1'b0;
      start_q <= 1'b0;
      dest_q  <= 1'b0;
      code_q  <= 1'b0;
    end else begin
      o_tx_wr <= wr_done & (i_apb.paddr == REG_UART);
      start_q <= wr_done & (i_apb.paddr == REG_BOOT);
      dest_q  <= wr_done & (i_apb.paddr == REG_CODE_DEST);
      code_q  <= wr_done & (i_apb.paddr == REG_CODE_DATA);
    end
  end

  always_ff @(posedge clk) begin
    if (wr_done)
      wdata_q <= i_apb.pwdata;                    // shared by every strobe
  end

  assign o_tx_byte = wdata_q[7:0];

  always_comb begin
    o_boot_cmd.start      = start_q;
    o_boot_cmd.flash_addr = wdata_q;              // both 24 bits
    o_boot_cmd.code_dest  = dest_q;
    o_boot_cmd.dest       = wdata_q[15:0];
    o_boot_cmd.code_data  = code_q;
    o_boot_cmd.code       = wdata_q[15:0];
  end

endmodule

//--- hdl/spif_top.sv
//================================================
// boot controller top: apb regs, uart paths, loader
//================================================
`timescale 1ns/10ps

module spif_top (
  input  logic                clk,
  input  logic                arstn,
  input  spif_pkg::apb_req_t  i_apb,
  output spif_pkg::apb_rsp_t  o_apb,
  input  logic                i_u_ready,
  input  logic                i_u_full,
  input  spif_pkg::byte_t     i_u_din,
  output logic                o_u_wr,
  output logic                o_u_rd,
  output spif_pkg::byte_t     o_u_dout,
  input  logic                i_f_ready,
  input  spif_pkg::byte_t     i_f_din,
  output logic                o_f_wr,
  output spif_pkg::byte_t     o_f_dout,
  output logic                o_f_cs_n,
  output spif_pkg::mem_wr_t   o_mem,
  output logic                o_p_reset
);
  import spif_pkg::*;

  byte_t     rx_byte;           // unescaped rx holding reg
  logic      rx_full;
  logic      rx_pop;            // apb read of REG_UART
  logic      tx_wr;
  byte_t     tx_byte;
  logic      tx_busy;
  logic      booting;
  boot_cmd_t boot_cmd;

  spif_regs u_regs (
    .clk(clk), .arstn(arstn), .i_apb(i_apb), .o_apb(o_apb),
    .i_rx_byte(rx_byte), .i_rx_full(rx_full), .i_tx_busy(tx_busy),
    .i_booting(booting), .o_tx_wr(tx_wr), .o_tx_byte(tx_byte),
    .o_rx_pop(rx_pop), .o_boot_cmd(boot_cmd)
  );

  uart_tx_escape u_tx (
    .clk(clk), .arstn(arstn), .i_tx_wr(tx_wr), .i_tx_byte(tx_byte),
    .i_u_ready(i_u_ready), .o_u_wr(o_u_wr), .o_u_dout(o_u_dout),
    .o_tx_busy(tx_busy)
  );

  uart_rx_unescape u_rx (
    .clk(clk), .arstn(arstn), .i_u_full(i_u_full), .i_u_din(i_u_din),
    .o_u_rd(o_u_rd), .i_rx_pop(rx_pop), .o_rx_byte(rx_byte),
    .o_rx_full(rx_full)
  );

  boot_loader u_boot (
    .clk(clk), .arstn(arstn), .i_boot_cmd(boot_cmd), .i_f_ready(i_f_ready),
    .i_f_din(i_f_din), .o_f_wr(o_f_wr), .o_f_dout(o_f_dout),
    .o_f_cs_n(o_f_cs_n), .o_mem(o_mem), .o_p_reset(o_p_reset),
    .o_booting(booting)
  );

endmodule

//--- verif/tb_spif.sv
//================================================
// testbench: apb driver, flash and uart models,
// boot image builder and compare tasks
//================================================
`timescale 1ns/10ps

module tb_spif;
  import spif_pkg::*;

  localparam logic [31:0] SEED     = 32'hbf98cdd4;
  localparam int          TIMEOUT  = 2000;        // cycles or polls per wait

  logic      clk;
  logic      arstn;
  apb_req_t  i_apb;
  apb_rsp_t  o_apb;
  logic      i_u_ready;
  logic      i_u_full;
  byte_t     i_u_din;
  logic      o_u_wr;
  logic      o_u_rd;
  byte_t     o_u_dout;
  logic      i_f_ready;
  byte_t     i_f_din;
  logic      o_f_wr;
  byte_t     o_f_dout;
  logic      o_f_cs_n;
  mem_wr_t   o_mem;
  logic      o_p_reset;

  logic [31:0] rng;                               // main stimulus
  logic [31:0] f_rng;                             // flash ready delays
  logic [31:0] u_rng;                             // uart sink ready

  int n_byte_err;
  int n_mem_err;
  int n_word_err;
  int n_other_err;

  byte_t       fmem [0:4095];                     // flash, low 12 address bits
  flash_addr_t img_ptr;                           // image write pointer
  dest_addr_t  img_dest;                          // model destination reg
  logic        exp_preset;                        // from the end command
  mem_wr_t     exp_mem [$];                       // expected RAM writes in order
  byte_t       tx_exp [$];                        // expected uart tx bytes
  byte_t       rx_raw [$];                        // raw uart source stream
  byte_t       rx_exp [$];                        // unescaped bytes to read back
  byte_t       f_hdr [$];                         // opcode and address seen by flash
  logic        src_hold;                          // gates the uart source

  int          f_xfer;                            // exchange index since cs# fell
  int          f_wait;                            // ready low cycles left
  byte_t       f_pend;
  flash_addr_t f_addr;                            // address sent by the DUT

  spif_top u_spif_top (
    .clk(clk), .arstn(arstn), .i_apb(i_apb), .o_apb(o_apb),
    .i_u_ready(i_u_ready), .i_u_full(i_u_full), .i_u_din(i_u_din),
    .o_u_wr(o_u_wr), .o_u_rd(o_u_rd), .o_u_dout(o_u_dout),
    .i_f_ready(i_f_ready), .i_f_din(i_f_din), .o_f_wr(o_f_wr),
    .o_f_dout(o_f_dout), .o_f_cs_n(o_f_cs_n), .o_mem(o_mem),
    .o_p_reset(o_p_reset)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;                        // 4 ns period
  end

  function automatic logic [31:0] xorshift(inout logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  //================================================
  // compare tasks
  //================================================
  task automatic check_byte(input byte_t got, input byte_t exp, input string what);
    if (got !== exp) begin
      n_byte_err++;
      $display("FAIL t=%0t: %s got %02h expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic check_word(input data_word_t got, input data_word_t exp,
                            input string what);
    if (got !== exp) begin
      n_word_err++;
      $display("FAIL t=%0t: %s got %06h expected %06h", $time, what, got, exp);
    end
  endtask

  task automatic check_mem(input mem_wr_t got, input mem_wr_t exp);
    logic ok;
    ok = (got.code_we === exp.code_we) && (got.data_we === exp.data_we) &&
         (got.addr === exp.addr);
    if (exp.code_we)
      ok = ok && (got.data[15:0] === exp.data[15:0]);   // code RAM keeps 16 bits
    else
      ok = ok && (got.data === exp.data);
    if (!ok) begin
      n_mem_err++;
      $display("FAIL t=%0t: ram write c%b d%b @%04h = %06h expected c%b d%b @%04h = %06h",
               $time, got.code_we, got.data_we, got.addr, got.data,
               exp.code_we, exp.data_we, exp.addr, exp.data);
    end
  endtask

  task automatic finish_run();
    $display("errors: byte %0d, ram %0d, word %0d, other %0d",
             n_byte_err, n_mem_err, n_word_err, n_other_err);
    if (n_byte_err + n_mem_err + n_word_err + n_other_err == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  endtask

  task automatic report_timeout(input string what);
    n_other_err++;
    $display("timed out at %0t while waiting for %s", $time, what);
    finish_run();
  endtask

  //================================================
  // apb master, driven on the falling edge
  //================================================
  task automatic apb_xfer(input logic wr, input reg_addr_t addr,
                          input data_word_t wdata, output data_word_t rdata);
    int n;
    n = 0;
    @(negedge clk);
    i_apb.psel    = 1'b1;                         // setup cycle
    i_apb.penable = 1'b0;
    i_apb.pwrite  = wr;
    i_apb.paddr   = addr;
    i_apb.pwdata  = wdata;
    @(negedge clk);
    i_apb.penable = 1'b1;
    #1;                                           // sample mid low phase
    while (!o_apb.pready) begin
      n++;
      if (n > TIMEOUT)
        report_timeout("pready");
      @(negedge clk);
      #1;
    end
    rdata = o_apb.prdata;                         // transfer ends on next posedge
    @(negedge clk);
    i_apb.psel    = 1'b0;
    i_apb.penable = 1'b0;
    i_apb.pwrite  = 1'b0;
  endtask

  task automatic write_reg(input reg_addr_t addr, input data_word_t wdata);
    data_word_t unused;
    apb_xfer(1'b1, addr, wdata, unused);
  endtask

  task automatic read_reg(input reg_addr_t addr, output data_word_t rdata);
    apb_xfer(1'b0, addr, '0, rdata);
  endtask

  task automatic poll_reg(input reg_addr_t addr, input data_word_t exp, input string what);
    data_word_t rd;
    int n;
    n = 0;
    read_reg(addr, rd);
    while (rd !== exp) begin
      n++;
      if (n > TIMEOUT)
        report_timeout(what);
      read_reg(addr, rd);
    end
  endtask

  task automatic wait_queues_empty(input string what);
    int n;
    n = 0;
    while (tx_exp.size() != 0 || exp_mem.size() != 0) begin
      n++;
      if (n > TIMEOUT)
        report_timeout(what);
      @(negedge clk);
    end
  endtask

  //================================================
  // boot image builder
  //================================================
  task automatic put_byte(input byte_t b);
    fmem[img_ptr[11:0]] = b;
    img_ptr = img_ptr + 1;
  endtask

  task automatic build_image(input flash_addr_t base);
    logic [31:0] r;
    logic [31:0] v;
    byte_t       b;
    mem_wr_t     e;
    logic [2:0]  sinkf;                           // 0 code, 1 data, else dropped
    logic [1:0]  nbm1;                            // bytes per word minus one
    int          nblk;
    int          nwords;
    img_ptr = base;
    nblk = 3 + int'(xorshift(rng) % 3);
    for (int k = 0; k < nblk; k++) begin
      r = xorshift(rng);
      if (r[0]) begin                             // byte the interpreter skips
        b = r[1] ? {2'b10, r[7:2]} : {3'b110, r[6:2]};
        if (b == 8'hC0 || b == 8'hC2)
          b = 8'hC1;
        put_byte(b);
      end
      if (k == 0 || r[8]) begin
        img_dest = r[31:16];
        put_byte(8'hC0);
        put_byte(r[31:24]);
        put_byte(r[23:16]);
      end
      nwords = 1 + int'(r[10:9] % 3);
      put_byte(8'hC2);                            // count is words minus one
      put_byte(8'h00);
      put_byte(byte_t'(nwords - 1));
      if (r[13:11] < 3)
        sinkf = 3'd0;
      else if (r[13:11] < 6)
        sinkf = 3'd1;
      else
        sinkf = 3'd2 + {1'b0, r[17:16]};
      nbm1 = r[15:14];
      put_byte({1'b0, r[19], r[18], sinkf, nbm1});
      for (int w = 0; w < nwords; w++) begin
        r = xorshift(rng);
        v = '0;
        for (int j = int'(nbm1); j >= 0; j--) begin
          b = r[8*j +: 8];                        // msb first
          put_byte(b);
          v = {v[23:0], b};
        end
        if (sinkf < 3'd2) begin
          e = '0;
          e.code_we = (sinkf == 3'd0);
          e.data_we = (sinkf == 3'd1);
          e.addr    = img_dest;
          e.data    = v[23:0];                    // 4-byte word keeps low 24 bits
          exp_mem.push_back(e);
        end
        img_dest = img_dest + 1;                  // dropped words still advance
      end
    end
    r = xorshift(rng);
    exp_preset = ~exp_preset;                     // each boot moves p_reset
    put_byte({3'b111, exp_preset, r[3:0]});
  endtask

  task automatic check_boot_end(input flash_addr_t base);
    if (f_hdr.size() != 4) begin
      n_other_err++;
      $display("flash received %0d command bytes instead of 4 at %0t", f_hdr.size(), $time);
    end else begin
      check_byte(f_hdr[0], FAST_READ, "flash opcode");
      check_byte(f_hdr[1], base[23:16], "flash address high");
      check_byte(f_hdr[2], base[15:8], "flash address mid");
      check_byte(f_hdr[3], base[7:0], "flash address low");
    end
    f_hdr.delete();
    if (exp_mem.size() != 0) begin
      n_other_err++;
      $display("%0d expected RAM writes never came at %0t", exp_mem.size(), $time);
      exp_mem.delete();
    end
    check_word(data_word_t'(o_p_reset), data_word_t'(exp_preset), "processor reset");
    check_word(data_word_t'(o_f_cs_n), 1, "flash chip select after end");
  endtask

  //================================================
  // behavioral models, all on the falling edge
  //================================================
  always @(negedge clk) begin : flash_model
    flash_addr_t fa;
    if (f_wait > 0) begin
      f_wait = f_wait - 1;
      if (f_wait == 0) begin
        i_f_din   = f_pend;
        i_f_ready = 1'b1;
      end
    end
    if (o_f_cs_n)
      f_xfer = 0;
    if (o_f_wr === 1'b1) begin
      if (f_xfer < 4)
        f_hdr.push_back(o_f_dout);                // opcode and address
      if (f_xfer >= 1 && f_xfer <= 3)
        f_addr = {f_addr[15:0], o_f_dout};
      fa = f_addr + flash_addr_t'(f_xfer - 5);
      f_pend = (f_xfer >= 5) ? fmem[fa[11:0]] : 8'hFF;  // first data after dummy
      f_xfer++;
      f_wait = int'(xorshift(f_rng) % 4);
      if (f_wait == 0)
        i_f_din = f_pend;
      else
        i_f_ready = 1'b0;
    end
  end

  always @(negedge clk) begin : uart_sink
    byte_t exp_b;
    i_u_ready = (xorshift(u_rng) % 4) != 0;
    if (o_u_wr === 1'b1) begin
      if (tx_exp.size() == 0) begin
        n_other_err++;
        $display("unexpected byte %02h on the uart transmit port at %0t", o_u_dout, $time);
      end else begin
        exp_b = tx_exp.pop_front();
        check_byte(o_u_dout, exp_b, "uart tx byte");
      end
    end
  end

  always @(negedge clk) begin : uart_source
    byte_t dropped;
    if (o_u_rd === 1'b1 && rx_raw.size() > 0)
      dropped = rx_raw.pop_front();               // popped by the DUT
    i_u_full = !src_hold && (rx_raw.size() > 0);
    i_u_din  = (rx_raw.size() > 0) ? rx_raw[0] : 8'h00;
  end

  always @(negedge clk) begin : ram_monitor
    mem_wr_t e;
    if (o_mem.code_we === 1'b1 || o_mem.data_we === 1'b1) begin
      if (exp_mem.size() == 0) begin
        n_other_err++;
        $display("unexpected RAM write to %04h at %0t", o_mem.addr, $time);
      end else begin
        e = exp_mem.pop_front();
        check_mem(o_mem, e);
      end
    end
  end

  //================================================
  // tests
  //================================================
  task automatic run_tx_test();
    logic [31:0] r;
    byte_t b;
    repeat (12) begin
      r = xorshift(rng);
      b = (r[1:0] == 2'd0) ? {6'b000100, r[9:8]} : r[15:8];   // bias toward escapes
      if (b[7:2] == ESC_BYTE[7:2]) begin
        tx_exp.push_back(ESC_BYTE);
        tx_exp.push_back({6'b000000, b[1:0]});
      end else begin
        tx_exp.push_back(b);
      end
      write_reg(REG_UART, data_word_t'(b));
    end
    wait_queues_empty("uart transmit bytes");
  endtask

  task automatic run_rx_test();
    logic [31:0] r;
    byte_t       b;
    byte_t       exp_b;
    data_word_t  rd;
    repeat (14) begin
      r = xorshift(rng);
      case (r[1:0])
        2'd0: begin                               // escape pair
          rx_raw.push_back(ESC_BYTE);
          rx_raw.push_back({6'b000000, r[9:8]});
          rx_exp.push_back({6'b000100, r[9:8]});
        end
        2'd1: rx_raw.push_back(byte_t'(8'h11 + r[9:8] % 3));  // stray, dropped
        default: begin
          b = r[15:8];
          if (b[7:2] == ESC_BYTE[7:2])
            b = b ^ 8'h40;
          rx_raw.push_back(b);
          rx_exp.push_back(b);
        end
      endcase
    end
    while (rx_exp.size() > 0) begin
      exp_b = rx_exp.pop_front();
      src_hold = 1'b0;
      poll_reg(REG_RX_FULL, 1, "received uart byte");
      src_hold = 1'b1;                            // keep the holding reg empty after the read
      read_reg(REG_UART, rd);
      check_byte(rd[7:0], exp_b, "uart rx byte");
      read_reg(REG_RX_FULL, rd);
      check_word(rd, 0, "rx full after read");
    end
  endtask

  task automatic run_code_test();
    logic [31:0] r;
    dest_addr_t  d;
    mem_wr_t     e;
    r = xorshift(rng);
    d = r[15:0];
    write_reg(REG_CODE_DEST, data_word_t'(d));
    repeat (5) begin
      r = xorshift(rng);
      e = '0;
      e.code_we = 1'b1;
      e.addr    = d;
      e.data    = data_word_t'(r[15:0]);
      exp_mem.push_back(e);
      write_reg(REG_CODE_DATA, r[23:0]);          // top byte ignored by code RAM
      d = d + 1;
    end
    wait_queues_empty("apb code writes");
  endtask

  initial begin : main
    logic [31:0] r;
    flash_addr_t base;
    rng         = SEED;
    f_rng       = SEED ^ 32'h5a5a0001;
    u_rng       = SEED ^ 32'h0000a5a5;
    n_byte_err  = 0;
    n_mem_err   = 0;
    n_word_err  = 0;
    n_other_err = 0;
    arstn       = 1'b0;
    i_apb       = '0;
    i_u_ready   = 1'b1;
    i_u_full    = 1'b0;
    i_u_din     = 8'h00;
    i_f_ready   = 1'b1;
    i_f_din     = 8'h00;
    src_hold    = 1'b1;
    f_xfer      = 0;
    f_wait      = 0;
    f_pend      = 8'h00;
    f_addr      = '0;
    img_dest    = '0;
    exp_preset  = 1'b1;                           // p_reset level out of reset
    for (int i = 0; i < 4096; i++)
      fmem[i] = byte_t'(i ^ (i >> 4));            // unused flash pattern
    build_image(24'h000000);                      // power-up image
    repeat (2) @(negedge clk);
    arstn = 1'b1;
    check_word(data_word_t'(o_p_reset), 1, "processor reset after reset");
    poll_reg(REG_BOOT, 0, "power-up boot");
    check_boot_end(24'h000000);
    run_tx_test();
    run_rx_test();
    run_code_test();
    r = xorshift(rng);
    base = {r[23:12], 2'b10, r[9:0]};             // clear of the first image
    build_image(base);
    write_reg(REG_BOOT, data_word_t'(base));
    poll_reg(REG_BOOT, 0, "reboot");
    check_boot_end(base);
    finish_run();
  end

endmodule

//--- spif.f
hdl/spif_pkg.sv
hdl/uart_tx_escape.sv
hdl/uart_rx_unescape.sv
hdl/boot_loader.sv
hdl/spif_regs.sv
hdl/spif_top.sv
verif/tb_spif.sv
